// ==== sqrt_defines.svh ====
`ifndef SQRT_DEFINES_SVH
`define SQRT_DEFINES_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// Radicand width
`define SQ_RAD_W        22
// Root width, half of the radicand
`define SQ_ROOT_W       11
// Full iteration count, one root bit per step
`define SQ_ITERS        `SQ_ROOT_W
// Normalization shift 2k, holds up to 20
`define SQ_SHIFT_W      5
// Remaining steps of the loop
`define SQ_STEP_W       4

// ----------------------------------------------------------------------
// Wishbone bus
// ----------------------------------------------------------------------

`define SQ_WB_DAT_W     32
// Word address, four slots
`define SQ_WB_ADR_W     2

// Register map in words
`define SQ_REG_RADICAND 2'd0
`define SQ_REG_STATUS   2'd1
`define SQ_REG_ROOT     2'd2

`endif

// ==== sqrt_pkg.sv ====
`default_nettype none

`include "sqrt_defines.svh"

// Types shared by the square-root datapath
package sqrt_pkg;

    // ------------------------------------------------------------------
    // Operand and result
    // ------------------------------------------------------------------

    // Integer radicand as written over the bus
    typedef logic [`SQ_RAD_W-1:0] radicand_t;

    // Floor of the square root
    typedef logic [`SQ_ROOT_W-1:0] root_t;

    // ------------------------------------------------------------------
    // Loop control
    // ------------------------------------------------------------------

    // Even left shift 2k applied by normalization
    typedef logic [`SQ_SHIFT_W-1:0] shift_t;

    // Steps left in the loop
    // Also wide enough for k itself
    typedef logic [`SQ_STEP_W-1:0] step_t;

endpackage

`default_nettype wire

// ==== wb_regs_pkg.sv ====
`default_nettype none

`include "sqrt_defines.svh"

// Types seen from the bus side of the register block
package wb_regs_pkg;

    // Word offsets of the three registers
    // Offset 3 is unmapped
    typedef enum logic [`SQ_WB_ADR_W-1:0] {
        REG_RADICAND = `SQ_REG_RADICAND,
        REG_STATUS   = `SQ_REG_STATUS,
        REG_ROOT     = `SQ_REG_ROOT
    } reg_addr_t;

    // STATUS word, busy in bit 1 and done in bit 0
    typedef struct packed {
        logic busy;
        logic done;
    } status_t;

endpackage

`default_nettype wire

// ==== sqrt_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sqrt_defines.svh"

module sqrt_regs (
    input  wire logic                      clk,
    input  wire logic                      rst,
    // Wishbone classic slave
    input  wire logic                      wb_cyc,
    input  wire logic                      wb_stb,
    input  wire logic                      wb_we,
    input  wire logic [`SQ_WB_ADR_W-1:0]   wb_adr,
    input  wire logic [`SQ_WB_DAT_W-1:0]   wb_dat_w,
    output logic      [`SQ_WB_DAT_W-1:0]   wb_dat_r,
    output logic                           wb_ack,
    // Result from the loop
    input  wire logic                      root_valid,
    input  wire sqrt_pkg::root_t           root,
    // Operand to normalization
    output logic                           start,
    output sqrt_pkg::radicand_t            radicand
);
    import sqrt_pkg::*;
    import wb_regs_pkg::*;

    localparam int DAT_W = `SQ_WB_DAT_W;

    reg_addr_t addr;
    logic      req;
    logic      rad_wr;
    status_t   status_q;
    root_t     root_q;

    // ------------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------------

    assign addr = reg_addr_t'(wb_adr);

    // New access seen, ack not yet given
    assign req = wb_cyc & wb_stb & ~wb_ack;

    // Radicand write only taken when idle
    assign rad_wr = req & wb_we & (addr == REG_RADICAND) & ~status_q.busy;

    // ------------------------------------------------------------------
    // Control and status
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            start    <= 1'b0;
            status_q <= '0;
            root_q   <= '0;
        end else begin
            // Ack one cycle after the request, for one cycle
            wb_ack <= req;
            start  <= 1'b0;
            if (rad_wr) begin
                start         <= 1'b1;
                status_q.busy <= 1'b1;
                status_q.done <= 1'b0;
            end
            // Busy blocks new writes, so no clash with rad_wr
            if (root_valid) begin
                status_q.busy <= 1'b0;
                status_q.done <= 1'b1;
                root_q        <= root;
            end
        end
    end

    // ------------------------------------------------------------------
    // Radicand and read data
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rad_wr) begin
            radicand <= wb_dat_w[`SQ_RAD_W-1:0];
        end
        // Read data held through the ack cycle
        if (req) begin
            case (addr)
                REG_RADICAND: wb_dat_r <= DAT_W'(radicand);
                REG_STATUS:   wb_dat_r <= DAT_W'(status_q);
                REG_ROOT:     wb_dat_r <= DAT_W'(root_q);
                default:      wb_dat_r <= '0;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    // Ack is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");

    // A start only ever leaves an idle unit
    assert property (@(posedge clk) disable iff (rst) start |-> $past(!status_q.busy))
        else $error("start issued while busy");

endmodule

`default_nettype wire

// ==== sqrt_normalize.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sqrt_defines.svh"

module sqrt_normalize (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire sqrt_pkg::radicand_t   radicand,
    output logic                       norm_valid,
    output sqrt_pkg::radicand_t        norm_radicand,
    output sqrt_pkg::shift_t           norm_shift,
    output logic                       norm_zero
);
    import sqrt_pkg::*;

    logic      zero;
    logic      found;
    shift_t    shift;
    radicand_t shifted;

    // Zero detection over the whole radicand
    assign zero = ~|radicand;

    // Even leading-zero count, first nonzero pair from the top
    always_comb begin
        found = 1'b0;
        shift = '0;
        for (int i = 0; i < `SQ_ROOT_W; i++) begin
            if (!found && radicand[`SQ_RAD_W-1-2*i -: 2] != 2'b00) begin
                found = 1'b1;
                shift = shift_t'(2 * i);
            end
        end
    end

    // Left barrel shifter, one stage per shift bit
    always_comb begin
        shifted = radicand;
        for (int b = 0; b < `SQ_SHIFT_W; b++) begin
            if (shift[b]) begin
                shifted = shifted << (1 << b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            norm_valid <= 1'b0;
        end else begin
            norm_valid <= start;
        end
    end

    // Payload captured with the start pulse
    always_ff @(posedge clk) begin
        if (start) begin
            norm_radicand <= shifted;
            norm_shift    <= shift;
            norm_zero     <= zero;
        end
    end

    // Nonzero operands leave with the top pair occupied
    assert property (@(posedge clk) disable iff (rst)
        norm_valid && !norm_zero |-> norm_radicand[`SQ_RAD_W-1 -: 2] != 2'b00)
        else $error("normalized radicand has an empty top pair");

endmodule

`default_nettype wire

// ==== sqrt_iterate.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sqrt_defines.svh"

module sqrt_iterate (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  norm_valid,
    input  wire sqrt_pkg::radicand_t   norm_radicand,
    input  wire sqrt_pkg::shift_t      norm_shift,
    input  wire logic                  norm_zero,
    output logic                       root_valid,
    output sqrt_pkg::root_t            root
);
    import sqrt_pkg::*;

    // Remainder scaled to the fixed root position, plus one bit of headroom
    localparam int REM_W = `SQ_ROOT_W + 2;

    logic             running;
    step_t            count;
    step_t            half_shift;
    radicand_t        rad_q;
    logic [REM_W-1:0] rem_q;
    // Root bits collect left-aligned, mask marks the bit of this step
    root_t            root_acc;
    root_t            bit_mask;

    logic [1:0]       pair;
    logic [REM_W-1:0] cand;
    logic [REM_W-1:0] trial;
    logic [REM_W:0]   diff;
    logic             ge;
    root_t            root_next;
    root_t            root_shifted;

    // ------------------------------------------------------------------
    // One restoring step
    // ------------------------------------------------------------------

    always_comb begin
        // Next two radicand bits come down from the top
        pair = rad_q[`SQ_RAD_W-1 -: 2];
        cand = (rem_q << 1)
             + ({REM_W{pair[1]}} & (REM_W'(bit_mask) << 1))
             + ({REM_W{pair[0]}} & REM_W'(bit_mask));
        // Trial 4q+1 at the same scale
        trial = (REM_W'(root_acc) << 1) + REM_W'(bit_mask);
        // Compare through the borrow of the subtraction
        diff      = {1'b0, cand} - {1'b0, trial};
        ge        = ~diff[REM_W];
        root_next = ge ? (root_acc | bit_mask) : root_acc;
    end

    // Denormalize, right barrel shift by k
    always_comb begin
        root_shifted = root_next;
        for (int b = 0; b < `SQ_STEP_W; b++) begin
            if (half_shift[b]) begin
                root_shifted = root_shifted >> (1 << b);
            end
        end
    end

    // ------------------------------------------------------------------
    // Step counter and loop control
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            running    <= 1'b0;
            count      <= '0;
            root_valid <= 1'b0;
        end else begin
            root_valid <= 1'b0;
            if (norm_valid) begin
                if (norm_zero) begin
                    // Nothing to iterate
                    root_valid <= 1'b1;
                end else begin
                    running <= 1'b1;
                    count   <= step_t'(`SQ_ITERS) - norm_shift[`SQ_SHIFT_W-1:1];
                end
            end else if (running) begin
                count <= count - 1'b1;
                if (count == step_t'(1)) begin
                    running    <= 1'b0;
                    root_valid <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Datapath registers
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (norm_valid) begin
            rad_q      <= norm_radicand;
            rem_q      <= '0;
            root_acc   <= '0;
            bit_mask   <= root_t'(1) << (`SQ_ROOT_W - 1);
            half_shift <= norm_shift[`SQ_SHIFT_W-1:1];
        end else if (running) begin
            rad_q    <= rad_q << 2;
            // Restore by keeping the candidate when the trial does not fit
            rem_q    <= ge ? diff[REM_W-1:0] : cand;
            root_acc <= root_next;
            bit_mask <= bit_mask >> 1;
        end
    end

    // Result register, written on the last step or for a zero operand
    always_ff @(posedge clk) begin
        if (norm_valid && norm_zero) begin
            root <= '0;
        end else if (running && count == step_t'(1)) begin
            root <= root_shifted;
        end
    end

    // Counter stays above zero while the loop runs
    assert property (@(posedge clk) disable iff (rst) running |-> count != '0)
        else $error("step counter underflow");

endmodule

`default_nettype wire

// ==== sqrt_wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sqrt_defines.svh"

module sqrt_wb_top (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      wb_cyc,
    input  wire logic                      wb_stb,
    input  wire logic                      wb_we,
    input  wire logic [`SQ_WB_ADR_W-1:0]   wb_adr,
    input  wire logic [`SQ_WB_DAT_W-1:0]   wb_dat_w,
    output logic      [`SQ_WB_DAT_W-1:0]   wb_dat_r,
    output logic                           wb_ack
);
    import sqrt_pkg::*;

    // Register block to normalization
    logic      start;
    radicand_t radicand;

    // Normalization to the loop
    logic      norm_valid;
    radicand_t norm_radicand;
    shift_t    norm_shift;
    logic      norm_zero;

    // Loop back to the register block
    logic      root_valid;
    root_t     root;

    // ------------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------------

    sqrt_regs sqrt_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .root_valid (root_valid),
        .root       (root),
        .start      (start),
        .radicand   (radicand)
    );

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------

    sqrt_normalize sqrt_normalize_inst (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .radicand      (radicand),
        .norm_valid    (norm_valid),
        .norm_radicand (norm_radicand),
        .norm_shift    (norm_shift),
        .norm_zero     (norm_zero)
    );

    sqrt_iterate sqrt_iterate_inst (
        .clk           (clk),
        .rst           (rst),
        .norm_valid    (norm_valid),
        .norm_radicand (norm_radicand),
        .norm_shift    (norm_shift),
        .norm_zero     (norm_zero),
        .root_valid    (root_valid),
        .root          (root)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock, starts low
module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period per phase
    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb_sqrt_wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sqrt_defines.svh"

module tb_sqrt_wb_top;
    import sqrt_pkg::*;
    import wb_regs_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int FIXED_ROWS   = 11;
    localparam int RANDOM_ROWS  = 16;
    localparam int NUM_ROWS     = FIXED_ROWS + RANDOM_ROWS;
    // Two extra row budgets cover the reset reads and the busy test
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + 2) * 200 + RESET_CYCLES;
    localparam logic [31:0] SEED = 32'hf83a_5b39;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`SQ_WB_ADR_W-1:0] wb_adr;
    logic [`SQ_WB_DAT_W-1:0] wb_dat_w;
    logic [`SQ_WB_DAT_W-1:0] wb_dat_r;
    logic                    wb_ack;

    // Stimulus table with a radicand and an expected root per row
    radicand_t rad_table [NUM_ROWS];
    root_t     root_table[NUM_ROWS];

    tb_clock_gen #(.PERIOD_NS(20)) tb_clock_gen_inst (
        .clk (clk)
    );

    sqrt_wb_top sqrt_wb_top_inst (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // ------------------------------------------------------------------
    // Reference model and failure reporting
    // ------------------------------------------------------------------

    // Largest r with r*r not above x by plain search
    function automatic root_t floor_sqrt(input radicand_t x);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= int'(x)) begin
            r++;
        end
        return root_t'(r);
    endfunction

    function automatic status_t make_status(input logic busy, input logic done);
        status_t s;
        s.busy = busy;
        s.done = done;
        return s;
    endfunction

    task automatic report_failure(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic check_root(input root_t got, input root_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: root %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: busy=%b done=%b, expected busy=%b done=%b",
                                     what, got.busy, got.done, exp.busy, exp.done));
        end
    endtask

    // Whole bus word for radicand readback and unmapped reads
    task automatic check_data(input logic [`SQ_WB_DAT_W-1:0] got,
                              input logic [`SQ_WB_DAT_W-1:0] exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: data 0x%08h, expected 0x%08h", what, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // Wishbone classic master
    // ------------------------------------------------------------------

    // Called just after a drive point and returns at the next one
    task automatic wb_write(input logic [`SQ_WB_ADR_W-1:0] adr,
                            input logic [`SQ_WB_DAT_W-1:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        @(posedge clk);
        #DRIVE_DELAY;
        // Hold the request until the slave acks
        while (!wb_ack) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
    endtask

    task automatic wb_read(input logic [`SQ_WB_ADR_W-1:0] adr,
                           output logic [`SQ_WB_DAT_W-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(posedge clk);
        #DRIVE_DELAY;
        while (!wb_ack) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        // Read data valid with the ack
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // Poll STATUS until done is set
    task automatic wait_done();
        logic [`SQ_WB_DAT_W-1:0] data;
        status_t                 st;
        st = '0;
        while (!st.done) begin
            wb_read(`SQ_REG_STATUS, data);
            st = status_t'(data[1:0]);
        end
    endtask

    // ------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT never finished", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        logic [`SQ_WB_DAT_W-1:0] data;
        logic [31:0]             rnd;
        radicand_t               first_rad;
        radicand_t               second_rad;

        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rst      = 1'b1;

        // One seeding call for the whole run
        rnd = $urandom(SEED);

        // Fixed rows with hand-worked roots
        rad_table[0]   = 22'd0;
        root_table[0]  = 11'd0;
        rad_table[1]   = 22'd1;
        root_table[1]  = 11'd1;
        rad_table[2]   = 22'd2;
        root_table[2]  = 11'd1;
        rad_table[3]   = 22'd3;
        root_table[3]  = 11'd1;
        rad_table[4]   = 22'd4;
        root_table[4]  = 11'd2;
        rad_table[5]   = 22'd15;
        root_table[5]  = 11'd3;
        rad_table[6]   = 22'd16;
        root_table[6]  = 11'd4;
        rad_table[7]   = 22'd17;
        root_table[7]  = 11'd4;
        rad_table[8]   = 22'd1000000;
        root_table[8]  = 11'd1000;
        rad_table[9]   = 22'd1048576;
        root_table[9]  = 11'd1024;
        rad_table[10]  = 22'h3f_ffff;
        root_table[10] = 11'd2047;

        // Random rows shifted down to spread the normalization amount
        for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
            rnd = $urandom;
            rad_table[i]  = radicand_t'(rnd[`SQ_RAD_W-1:0] >> ($urandom % `SQ_RAD_W));
            root_table[i] = floor_sqrt(rad_table[i]);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Idle state after reset
        wb_read(`SQ_REG_STATUS, data);
        check_status(status_t'(data[1:0]), make_status(1'b0, 1'b0), "status after reset");
        wb_read(`SQ_REG_ROOT, data);
        check_root(root_t'(data[`SQ_ROOT_W-1:0]), '0, "root after reset");

        // Table rows
        for (int i = 0; i < NUM_ROWS; i++) begin
            wb_write(`SQ_REG_RADICAND, `SQ_WB_DAT_W'(rad_table[i]));
            wait_done();
            wb_read(`SQ_REG_ROOT, data);
            check_root(root_t'(data[`SQ_ROOT_W-1:0]), root_table[i],
                       $sformatf("row %0d radicand %0d", i, rad_table[i]));
            wb_read(`SQ_REG_STATUS, data);
            check_status(status_t'(data[1:0]), make_status(1'b0, 1'b1),
                         $sformatf("status after row %0d", i));
            wb_read(`SQ_REG_RADICAND, data);
            check_data(data, `SQ_WB_DAT_W'(rad_table[i]),
                       $sformatf("radicand readback row %0d", i));
        end

        // Second write right behind a start lands while busy
        first_rad  = 22'h3f_ffff;
        second_rad = 22'd9;
        wb_write(`SQ_REG_RADICAND, `SQ_WB_DAT_W'(first_rad));
        wb_write(`SQ_REG_RADICAND, `SQ_WB_DAT_W'(second_rad));
        wait_done();
        wb_read(`SQ_REG_ROOT, data);
        check_root(root_t'(data[`SQ_ROOT_W-1:0]), floor_sqrt(first_rad),
                   "root after write while busy");
        wb_read(`SQ_REG_RADICAND, data);
        check_data(data, `SQ_WB_DAT_W'(first_rad), "radicand after write while busy");

        // Unmapped slot reads zero and still acks
        wb_read(2'd3, data);
        check_data(data, '0, "unmapped address 3");

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sqrt_wb_top.f ====
+incdir+.
sqrt_pkg.sv
wb_regs_pkg.sv
sqrt_regs.sv
sqrt_normalize.sv
sqrt_iterate.sv
sqrt_wb_top.sv
tb_clock_gen.sv
tb_sqrt_wb_top.sv
